//--- design/rx_eq_pkg.sv
package rx_eq_pkg;

   localparam int lane_cnt_def = 4;
   localparam int tap_cnt_def = 3;

   typedef logic signed [7:0] code_t;   // raw ADC code
   typedef logic signed [7:0] weight_t;
   typedef logic signed [9:0] eq_t;     // equalized sample after saturation
   typedef logic [3:0] shift_t;
   typedef logic [3:0] conf_t;

   typedef logic [7:0] axil_addr_t;
   typedef logic [31:0] axil_data_t;
   typedef logic [$bits(axil_data_t)/8-1:0] axil_strb_t;
   typedef logic [1:0] axil_resp_t;

   typedef struct packed {
      axil_addr_t aw_addr;
      logic aw_valid;
      axil_data_t w_data;
      axil_strb_t w_strb;
      logic w_valid;
      logic b_ready;
      axil_addr_t ar_addr;
      logic ar_valid;
      logic r_ready;
   } axil_req_t;

   typedef struct packed {
      logic aw_ready;
      logic w_ready;
      axil_resp_t b_resp;
      logic b_valid;
      logic ar_ready;
      axil_data_t r_data;
      axil_resp_t r_resp;
      logic r_valid;
   } axil_rsp_t;

   localparam axil_addr_t reg_shift_addr = 8'h00;
   localparam axil_addr_t reg_thresh_addr = 8'h04;
   localparam axil_addr_t reg_weight_base = 8'h10;  // weight k at base + 4*k

   localparam axil_resp_t resp_okay = 2'b00;
   localparam axil_resp_t resp_slverr = 2'b10;

endpackage

//--- design/ffe.sv
`timescale 1ns/100ps

module ffe
   import rx_eq_pkg::*;
#(
   parameter int lane_cnt = 4,
   parameter int tap_cnt = 3
) (
   input  logic    clk,
   input  logic    arst_n,
   input  logic    codes_valid,
   input  code_t   codes [lane_cnt],
   input  weight_t weights [tap_cnt],
   input  shift_t  shift,
   output logic    eq_valid,
   output eq_t     eq [lane_cnt]
);

   localparam int hist_len = tap_cnt - 1;
   localparam int ext_len = lane_cnt + hist_len;
   localparam int prod_w = $bits(code_t) + $bits(weight_t);
   localparam int sum_w = prod_w + $clog2(tap_cnt + 1);  // headroom for the tap sum
   localparam int eq_max = 2 ** ($bits(eq_t) - 1) - 1;
   localparam int eq_min = -(2 ** ($bits(eq_t) - 1));

   code_t hist [hist_len];  // hist[0] is the oldest sample
   code_t ext [ext_len];    // history followed by the current block
   logic signed [sum_w-1:0] sum [lane_cnt];
   logic signed [sum_w-1:0] shifted [lane_cnt];
   eq_t eq_next [lane_cnt];

   always_comb begin
      for (int i = 0; i < hist_len; i++) begin
         ext[i] = hist[i];
      end
      for (int j = 0; j < lane_cnt; j++) begin
         ext[hist_len + j] = codes[j];
      end
   end

   // lane j is sample n, so tap k reaches back to ext[hist_len + j - k]
   always_comb begin
      for (int j = 0; j < lane_cnt; j++) begin
         sum[j] = '0;
         for (int k = 0; k < tap_cnt; k++) begin
            sum[j] = sum[j] + ext[hist_len + j - k] * weights[k];
         end
      end
   end

   always_comb begin
      for (int j = 0; j < lane_cnt; j++) begin
         shifted[j] = sum[j] >>> shift;  // arithmetic, keeps the sign
         if (shifted[j] > eq_max) begin
            eq_next[j] = eq_t'(eq_max);
         end else if (shifted[j] < eq_min) begin
            eq_next[j] = eq_t'(eq_min);
         end else begin
            eq_next[j] = eq_t'(shifted[j]);
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         eq_valid <= 1'b0;
         for (int i = 0; i < hist_len; i++) begin
            hist[i] <= '0;
         end
      end else begin
         eq_valid <= codes_valid;
         if (codes_valid) begin
            for (int i = 0; i < hist_len; i++) begin
               hist[i] <= ext[lane_cnt + i];  // newest samples of this block
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (codes_valid) begin
         eq <= eq_next;
      end
   end

   // the history window must fit in one previous block
   a_tap_range : assert property (@(posedge clk) tap_cnt >= 2 && tap_cnt <= lane_cnt + 1)
      else $error("tap_cnt %0d out of range for lane_cnt %0d", tap_cnt, lane_cnt);

endmodule

//--- design/slicer.sv
`timescale 1ns/100ps

module slicer
   import rx_eq_pkg::*;
#(
   parameter int lane_cnt = 4
) (
   input  logic  clk,
   input  logic  arst_n,
   input  logic  eq_valid,
   input  eq_t   eq [lane_cnt],
   input  code_t thresh,
   output logic  bits_valid,
   output logic  bits [lane_cnt],
   output conf_t conf [lane_cnt]
);

   localparam int diff_w = $bits(eq_t) + 1;
   localparam int conf_max = 2 ** $bits(conf_t) - 1;

   logic signed [diff_w-1:0] diff [lane_cnt];
   logic [diff_w-1:0] mag [lane_cnt];
   logic bit_next [lane_cnt];
   conf_t conf_next [lane_cnt];

   always_comb begin
      for (int j = 0; j < lane_cnt; j++) begin
         diff[j] = eq[j] - thresh;  // thresh is sign extended to the sample width
         bit_next[j] = (diff[j] >= 0);
         mag[j] = (diff[j] < 0) ? -diff[j] : diff[j];
         conf_next[j] = (mag[j] > conf_max) ? conf_t'(conf_max) : conf_t'(mag[j]);
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         bits_valid <= 1'b0;
      end else begin
         bits_valid <= eq_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (eq_valid) begin
         bits <= bit_next;
         conf <= conf_next;
      end
   end

endmodule

//--- design/eq_csr.sv
`timescale 1ns/100ps

module eq_csr
   import rx_eq_pkg::*;
#(
   parameter int tap_cnt = 3
) (
   input  logic      clk,
   input  logic      arst_n,
   input  axil_req_t axil_req,
   output axil_rsp_t axil_rsp,
   output weight_t   weights [tap_cnt],
   output shift_t    shift,
   output code_t     thresh
);

   logic init_done;  // slave opens its channels one cycle after reset
   logic wr_ready;
   logic wr_fire;
   logic rd_ready;
   logic rd_fire;
   logic b_valid;
   logic r_valid;
   axil_resp_t b_resp;
   axil_resp_t r_resp;
   axil_data_t r_data;
   axil_data_t rd_data;

   function automatic logic addr_mapped(axil_addr_t addr);
      logic hit;
      hit = (addr == reg_shift_addr) || (addr == reg_thresh_addr);
      for (int k = 0; k < tap_cnt; k++) begin
         if (addr == axil_addr_t'(reg_weight_base + 4 * k)) begin
            hit = 1'b1;
         end
      end
      return hit;
   endfunction

   assign wr_ready = init_done && !b_valid && axil_req.aw_valid && axil_req.w_valid;
   assign wr_fire = wr_ready;  // AW and W are taken together
   assign rd_ready = init_done && !r_valid;
   assign rd_fire = rd_ready && axil_req.ar_valid;

   always_comb begin
      rd_data = '0;  // unmapped reads return zero
      if (axil_req.ar_addr == reg_shift_addr) begin
         rd_data[$bits(shift_t)-1:0] = shift;
      end else if (axil_req.ar_addr == reg_thresh_addr) begin
         rd_data[$bits(code_t)-1:0] = thresh;
      end
      for (int k = 0; k < tap_cnt; k++) begin
         if (axil_req.ar_addr == axil_addr_t'(reg_weight_base + 4 * k)) begin
            rd_data[$bits(weight_t)-1:0] = weights[k];
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         init_done <= 1'b0;
         b_valid <= 1'b0;
         r_valid <= 1'b0;
      end else begin
         init_done <= 1'b1;
         if (wr_fire) begin
            b_valid <= 1'b1;
         end else if (axil_req.b_ready) begin
            b_valid <= 1'b0;
         end
         if (rd_fire) begin
            r_valid <= 1'b1;
         end else if (axil_req.r_ready) begin
            r_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         shift <= '0;
         thresh <= '0;
         for (int k = 0; k < tap_cnt; k++) begin
            weights[k] <= '0;
         end
      end else if (wr_fire && axil_req.w_strb[0]) begin  // all fields live in byte 0
         if (axil_req.aw_addr == reg_shift_addr) begin
            shift <= axil_req.w_data[$bits(shift_t)-1:0];
         end
         if (axil_req.aw_addr == reg_thresh_addr) begin
            thresh <= axil_req.w_data[$bits(code_t)-1:0];
         end
         for (int k = 0; k < tap_cnt; k++) begin
            if (axil_req.aw_addr == axil_addr_t'(reg_weight_base + 4 * k)) begin
               weights[k] <= axil_req.w_data[$bits(weight_t)-1:0];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr_fire) begin
         b_resp <= addr_mapped(axil_req.aw_addr) ? resp_okay : resp_slverr;
      end
      if (rd_fire) begin
         r_data <= rd_data;
         r_resp <= addr_mapped(axil_req.ar_addr) ? resp_okay : resp_slverr;
      end
   end

   always_comb begin
      axil_rsp.aw_ready = wr_ready;
      axil_rsp.w_ready = wr_ready;
      axil_rsp.b_resp = b_resp;
      axil_rsp.b_valid = b_valid;
      axil_rsp.ar_ready = rd_ready;
      axil_rsp.r_data = r_data;
      axil_rsp.r_resp = r_resp;
      axil_rsp.r_valid = r_valid;
   end

   a_b_hold : assert property (@(posedge clk) disable iff (!arst_n)
      b_valid && !axil_req.b_ready |=> b_valid)
      else $error("b_valid dropped before b_ready");

   a_r_hold : assert property (@(posedge clk) disable iff (!arst_n)
      r_valid && !axil_req.r_ready |=> r_valid)
      else $error("r_valid dropped before r_ready");

endmodule

//--- design/rx_eq_top.sv
`timescale 1ns/100ps

module rx_eq_top
   import rx_eq_pkg::*;
#(
   parameter int lane_cnt = lane_cnt_def,
   parameter int tap_cnt = tap_cnt_def
) (
   input  logic      clk,
   input  logic      arst_n,
   input  axil_req_t axil_req,
   output axil_rsp_t axil_rsp,
   input  logic      codes_valid,
   input  code_t     codes [lane_cnt],
   output logic      bits_valid,
   output logic      bits [lane_cnt],
   output conf_t     conf [lane_cnt]
);

   weight_t weights [tap_cnt];
   shift_t shift;
   code_t thresh;
   logic eq_valid;
   eq_t eq [lane_cnt];

   eq_csr #(.tap_cnt(tap_cnt)) csr_i (
      .clk     (clk),
      .arst_n  (arst_n),
      .axil_req(axil_req),
      .axil_rsp(axil_rsp),
      .weights (weights),
      .shift   (shift),
      .thresh  (thresh)
   );

   ffe #(.lane_cnt(lane_cnt), .tap_cnt(tap_cnt)) ffe_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .codes_valid(codes_valid),
      .codes      (codes),
      .weights    (weights),
      .shift      (shift),
      .eq_valid   (eq_valid),
      .eq         (eq)
   );

   slicer #(.lane_cnt(lane_cnt)) slicer_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .eq_valid  (eq_valid),
      .eq        (eq),
      .thresh    (thresh),
      .bits_valid(bits_valid),
      .bits      (bits),
      .conf      (conf)
   );

endmodule

//--- verification/clk_gen.sv
`timescale 1ns/100ps

module clk_gen #(
   parameter int half_period = 10,
   parameter int reset_cycles = 10
) (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk = 1'b0;
      forever #(half_period) clk = ~clk;
   end

   initial begin
      arst_n = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;  // release away from the active edge
   end

endmodule

//--- verification/rx_eq_tb.sv
`timescale 1ns/100ps

module rx_eq_tb
   import rx_eq_pkg::*;
();

   localparam int lane_cnt = 4;
   localparam int tap_cnt = 3;
   localparam int timeout = 100;  // cycles allowed for any single wait

   typedef struct packed {
      weight_t w0;
      weight_t w1;
      weight_t w2;
      shift_t shift;
      code_t thresh;
      logic restart;  // a zero block goes first so the history starts clean
      logic gap;      // idle cycles after every block
      logic rnd;      // codes come from $random instead of the code list
      int first;      // first block in the code list
      int nblk;
   } row_t;

   typedef struct packed {
      logic [lane_cnt-1:0] bits;
      logic [lane_cnt-1:0][3:0] conf;
   } exp_t;

   localparam row_t rows [7] = '{
      '{8'sd1, 8'sd0, 8'sd0, 4'd0, 8'sd0, 1'b1, 1'b0, 1'b0, 0, 3},
      '{8'sd2, -8'sd1, 8'sd3, 4'd0, 8'sd0, 1'b1, 1'b1, 1'b0, 3, 3},
      '{8'sd127, 8'sd127, 8'sd127, 4'd0, 8'sd0, 1'b0, 1'b0, 1'b0, 6, 2},
      '{8'sd127, 8'sd127, 8'sd127, 4'd8, 8'sd0, 1'b0, 1'b0, 1'b0, 6, 2},
      '{8'sd1, 8'sd0, 8'sd0, 4'd0, 8'sd10, 1'b0, 1'b0, 1'b0, 8, 2},
      '{8'sd3, -8'sd2, 8'sd1, 4'd1, -8'sd5, 1'b1, 1'b0, 1'b1, 0, 24},
      '{-8'sd60, 8'sd90, 8'sd40, 4'd3, 8'sd7, 1'b0, 1'b0, 1'b1, 0, 24}
   };

   localparam code_t code_list [40] = '{
      8'sd5, -8'sd3, 8'sd0, -8'sd100, 8'sd127, 8'sd1, -8'sd1, 8'sd20,
      -8'sd20, 8'sd16, -8'sd15, 8'sd0, 8'sd4, -8'sd7, 8'sd12, 8'sd1,
      -8'sd9, 8'sd3, 8'sd8, -8'sd2, 8'sd6, 8'sd6, -8'sd11, 8'sd5,
      8'sd127, 8'sd127, 8'sd127, 8'sd127, -8'sd127, -8'sd127, -8'sd127, -8'sd127,
      8'sd10, 8'sd9, 8'sd25, -8'sd6, 8'sd30, 8'sd11, -8'sd100, 8'sd3
   };

   logic clk;
   logic arst_n;
   axil_req_t axil_req;
   axil_rsp_t axil_rsp;
   logic codes_valid;
   code_t codes [lane_cnt];
   logic bits_valid;
   logic bits [lane_cnt];
   conf_t conf [lane_cnt];

   exp_t exp_q [$];
   exp_t got;
   int recent [$];  // newest sample last
   int w [tap_cnt];
   int sh;
   int th;
   int seed = 32'he315;
   logic [1:0] vpipe = '0;

   clk_gen clk_gen_i (
      .clk   (clk),
      .arst_n(arst_n)
   );

   rx_eq_top #(.lane_cnt(lane_cnt), .tap_cnt(tap_cnt)) dut_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .axil_req   (axil_req),
      .axil_rsp   (axil_rsp),
      .codes_valid(codes_valid),
      .codes      (codes),
      .bits_valid (bits_valid),
      .bits       (bits),
      .conf       (conf)
   );

   task automatic stop_run(string what);
      $display("%s", what);
      $display("Some tests failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check(string what, logic [31:0] actual, logic [31:0] expected);
      if (actual !== expected) begin
         stop_run($sformatf("Mismatch at %0t: %s, got %0d, expected %0d",
            $time, what, actual, expected));
      end
   endtask

   task automatic wait_rsp(string name);
      int n;
      logic seen;
      n = 0;
      seen = 1'b0;
      while (!seen) begin
         @(negedge clk);
         case (name)
            "aw_ready": seen = (axil_rsp.aw_ready === 1'b1);
            "ar_ready": seen = (axil_rsp.ar_ready === 1'b1);
            "b_valid": seen = (axil_rsp.b_valid === 1'b1);
            default: seen = (axil_rsp.r_valid === 1'b1);
         endcase
         n++;
         if (!seen && n > timeout) begin
            stop_run({"timeout waiting for ", name});
         end
      end
   endtask

   // for a read, data is the expected read data
   task automatic bus_access(logic wr, axil_addr_t addr, axil_data_t data, int hold,
                             axil_resp_t resp);
      string rdy;
      string vld;
      @(posedge clk);
      if (wr) begin
         axil_req.aw_addr <= addr;
         axil_req.aw_valid <= 1'b1;
         axil_req.w_data <= data;
         axil_req.w_valid <= 1'b1;
         rdy = "aw_ready";
         vld = "b_valid";
      end else begin
         axil_req.ar_addr <= addr;
         axil_req.ar_valid <= 1'b1;
         rdy = "ar_ready";
         vld = "r_valid";
      end
      wait_rsp(rdy);
      if (wr) begin
         check("w_ready together with aw_ready", axil_rsp.w_ready, 1);
      end
      @(posedge clk);  // request transfers on this edge
      axil_req.aw_valid <= 1'b0;
      axil_req.w_valid <= 1'b0;
      axil_req.ar_valid <= 1'b0;
      wait_rsp(vld);
      repeat (hold) @(negedge clk);
      check("response held while ready is low", wr ? axil_rsp.b_valid : axil_rsp.r_valid, 1);
      if (wr) begin
         check("write response", axil_rsp.b_resp, resp);
      end else begin
         check("read response", axil_rsp.r_resp, resp);
         check("read data", axil_rsp.r_data, data);
      end
      @(posedge clk);
      axil_req.b_ready <= wr;
      axil_req.r_ready <= !wr;
      @(posedge clk);
      axil_req.b_ready <= 1'b0;
      axil_req.r_ready <= 1'b0;
   endtask

   task automatic model_sample(input int code, output logic b, output logic [3:0] c);
      int acc;
      int y;
      int d;
      recent.push_back(code);
      acc = 0;
      for (int k = 0; k < tap_cnt; k++) begin
         acc += w[k] * recent[recent.size() - 1 - k];  // tap k sees sample n-k
      end
      void'(recent.pop_front());
      y = acc >>> sh;
      y = (y > 511) ? 511 : ((y < -512) ? -512 : y);  // 10-bit signed range
      d = y - th;
      b = (d >= 0);
      d = (d < 0) ? -d : d;
      c = (d > 15) ? 4'd15 : 4'(d);
   endtask

   task automatic send_block(code_t blk [lane_cnt]);
      exp_t e;
      logic b;
      logic [3:0] c;
      @(posedge clk);
      codes_valid <= 1'b1;
      for (int j = 0; j < lane_cnt; j++) begin
         codes[j] <= blk[j];
         model_sample(blk[j], b, c);
         e.bits[j] = b;
         e.conf[j] = c;
      end
      exp_q.push_back(e);
   endtask

   task automatic idle_cycles(int cnt);
      repeat (cnt) begin
         @(posedge clk);
         codes_valid <= 1'b0;
      end
   endtask

   always @(negedge clk) begin
      if (arst_n) begin
         check("bits_valid two cycles after codes_valid", bits_valid, vpipe[1]);
         if (bits_valid) begin
            if (exp_q.size() == 0) begin
               stop_run("an output block appeared that was never sent");
            end else begin
               got = exp_q.pop_front();
               for (int j = 0; j < lane_cnt; j++) begin
                  check($sformatf("bit of lane %0d", j), bits[j], got.bits[j]);
                  check($sformatf("conf of lane %0d", j), conf[j], got.conf[j]);
               end
            end
         end
      end
      vpipe <= {vpipe[0], codes_valid};
   end

   initial begin
      int n;
      code_t blk [lane_cnt];
      code_t zero_blk [lane_cnt];
      axil_req = '0;
      axil_req.w_strb = 4'h1;
      codes_valid = 1'b0;
      for (int j = 0; j < lane_cnt; j++) begin
         codes[j] = '0;
         zero_blk[j] = '0;
      end
      for (int k = 0; k < tap_cnt - 1; k++) begin
         recent.push_back(0);  // samples before the first block count as zero
      end
      n = 0;
      while (arst_n !== 1'b1) begin
         @(negedge clk);
         n++;
         if (n > timeout) begin
            stop_run("reset was never released");
         end
      end
      @(negedge clk);
      check("bits_valid after reset", bits_valid, 0);
      check("b_valid after reset", axil_rsp.b_valid, 0);
      check("r_valid after reset", axil_rsp.r_valid, 0);
      bus_access(1'b0, reg_shift_addr, '0, 0, resp_okay);
      bus_access(1'b0, reg_thresh_addr, '0, 0, resp_okay);
      for (int k = 0; k < tap_cnt; k++) begin
         bus_access(1'b0, axil_addr_t'(reg_weight_base + 4 * k), '0, 0, resp_okay);
      end

      bus_access(1'b1, reg_shift_addr, 32'h9, 3, resp_okay);
      bus_access(1'b1, reg_thresh_addr, 32'hc4, 2, resp_okay);
      bus_access(1'b1, reg_weight_base + 8'h08, 32'h81, 4, resp_okay);
      bus_access(1'b1, 8'h08, 32'hff, 3, resp_slverr);  // hole below the weights
      bus_access(1'b1, reg_weight_base + 8'h0c, 32'h55, 1, resp_slverr);  // no tap 3
      bus_access(1'b0, 8'h08, '0, 3, resp_slverr);
      bus_access(1'b0, reg_weight_base + 8'h0c, '0, 2, resp_slverr);
      bus_access(1'b0, reg_shift_addr, 32'h9, 4, resp_okay);
      bus_access(1'b0, reg_thresh_addr, 32'hc4, 3, resp_okay);
      bus_access(1'b0, reg_weight_base, '0, 1, resp_okay);
      bus_access(1'b0, reg_weight_base + 8'h04, '0, 2, resp_okay);
      bus_access(1'b0, reg_weight_base + 8'h08, 32'h81, 5, resp_okay);

      for (int i = 0; i < 7; i++) begin
         w[0] = rows[i].w0;
         w[1] = rows[i].w1;
         w[2] = rows[i].w2;
         sh = rows[i].shift;
         th = rows[i].thresh;
         for (int k = 0; k < tap_cnt; k++) begin
            bus_access(1'b1, axil_addr_t'(reg_weight_base + 4 * k), axil_data_t'(w[k]), 0,
               resp_okay);
         end
         bus_access(1'b1, reg_shift_addr, axil_data_t'(sh), 0, resp_okay);
         bus_access(1'b1, reg_thresh_addr, axil_data_t'(th), 0, resp_okay);
         if (rows[i].restart) begin
            send_block(zero_blk);  // zeros flush the history of DUT and model alike
         end
         for (int b = 0; b < rows[i].nblk; b++) begin
            for (int j = 0; j < lane_cnt; j++) begin
               if (rows[i].rnd) begin
                  blk[j] = code_t'($random(seed));
               end else begin
                  blk[j] = code_list[(rows[i].first + b) * lane_cnt + j];
               end
            end
            send_block(blk);
            if (rows[i].gap) begin
               idle_cycles(2);
            end
         end
         idle_cycles(1);
         n = 0;
         while (exp_q.size() != 0) begin
            @(negedge clk);
            n++;
            if (n > timeout) begin
               stop_run("equalizer output never arrived for all blocks");
            end
         end
      end
      $display("All tests passed");
      $finish;
   end

endmodule

//--- src.f
design/rx_eq_pkg.sv
design/ffe.sv
design/slicer.sv
design/eq_csr.sv
design/rx_eq_top.sv
verification/clk_gen.sv
verification/rx_eq_tb.sv

//--- Bender.yml
package:
  name: rx_eq

sources:
  - design/rx_eq_pkg.sv
  - design/ffe.sv
  - design/slicer.sv
  - design/eq_csr.sv
  - design/rx_eq_top.sv
  - target: test
    files:
      - verification/clk_gen.sv
      - verification/rx_eq_tb.sv
